// File: all.f
verilog/decode_pkg.sv
verilog/inst_skid_buffer.sv
verilog/inst_decoder.sv
verilog/ctrl_out_reg.sv
verilog/decode_stage.sv
test/decode_checker.sv
test/tb_decode_stage.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_decode_stage \
  -f all.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_decode_stage > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0

// File: test/decode_checker.sv
`timescale 1ns/1ps

module decode_checker
  import decode_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  inst_t        instruction,
  input  logic         inst_valid,
  input  logic         inst_ready,
  input  decode_ctrl_t ctrl,
  input  logic         ctrl_valid,
  input  logic         ctrl_ready,
  input  logic         latency_check,
  output int           error_count,
  output int           out_count,
  output int           pending
);

  decode_ctrl_t exp_q[$];
  int           accept_q[$];
  int           cycle;
  logic         stalled;
  decode_ctrl_t held_ctrl;

  // Expected bundle for one instruction word
  function automatic decode_ctrl_t expected_ctrl(input inst_t w);
    decode_ctrl_t e;
    logic         op2;
    e   = '0;
    op2 = w[12] ? 1'b0 : 1'b1;
    casez (w[15:12])
      4'b0001:
      begin
        e.rf.rd_addr  = w[7:4];
        e.alu.ext_8_16 = w[10];
        e.alu.opcode  = w[11] ? ALU_ZEX : ALU_SEX;
        e.wb          = '{write: 1'b1, source: 2'd0, addr: w[7:4]};
      end
      4'b001?:
      begin
        e.rf.rn_addr   = w[3:0];
        e.rf.literal   = {{24{w[7]}}, w[7:0]};
        e.alu.op2_select = op2;
        e.alu.opcode   = ALU_MOV;
        e.br           = '{is_branch: 1'b1, is_cond_branch: 1'b1, code: w[10:8]};
        e.wb           = '{write: w[11], source: 2'd2, addr: 4'd14};
      end
      4'b010?:
      begin
        e.rf.rn_addr     = w[3:0];
        e.rf.literal     = {24'd0, w[7:0]};
        e.alu.op2_select = op2;
        e.alu.opcode     = ALU_MOV;
        e.wb             = '{write: 1'b1, source: 2'd0, addr: w[11:8]};
      end
      4'b011?:
      begin
        e.rf.rd_addr     = w[7:4];
        e.rf.rn_addr     = w[11:8];
        e.rf.literal     = {28'd0, w[3:0]};
        e.alu.op2_select = 1'b1;
        e.alu.opcode     = ALU_ADD;
        e.mem.write      = w[12];
        e.mem.read       = !w[12];
        e.wb             = '{write: !w[12], source: 2'd1, addr: w[11:8]};
      end
      4'b100?:
      begin
        e.rf.rd_addr      = w[7:4];
        e.rf.rn_addr      = w[3:0];
        e.rf.literal      = {28'd0, w[3:0]};
        e.alu.op2_select  = op2;
        e.alu.opcode      = w[11:8];
        e.alu.store_flags = 4'hf;
        e.wb              = '{write: 1'b1, source: 2'd0, addr: w[7:4]};
      end
      4'b101?:
      begin
        e.rf.rd_addr      = w[11:8];
        e.rf.rn_addr      = w[3:0];
        e.rf.literal      = {27'd0, w[4:0]};
        e.alu.op2_select  = op2;
        e.alu.opcode      = ALU_LSR + {2'b00, w[7:6]};
        e.alu.store_flags = 4'hf;
        e.wb              = '{write: 1'b1, source: 2'd0, addr: w[11:8]};
      end
      4'b1111:
      begin
        e.rf.rd_addr   = w[3:0];
        e.rf.literal   = {22'd0, w[9:0]};
        e.br.is_branch = 1'b1;
        e.wb           = '{write: w[11], source: 2'd2, addr: 4'd14};
      end
      default:
        e = '0;
    endcase
    return e;
  endfunction

  task automatic compare_field(input string name, input logic [39:0] exp_v,
                               input logic [39:0] got_v);
    if (exp_v !== got_v)
    begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp_v, got_v);
      error_count++;
    end
  endtask

  task automatic check_output();
    decode_ctrl_t e;
    int           acc;
    if (exp_q.size() == 0)
    begin
      $display("Error at %0t: output transfer with no instruction outstanding", $time);
      error_count++;
    end
    else
    begin
      e   = exp_q.pop_front();
      acc = accept_q.pop_front();
      compare_field("ctrl.rf", 40'(e.rf), 40'(ctrl.rf));
      compare_field("ctrl.alu", 40'(e.alu), 40'(ctrl.alu));
      compare_field("ctrl.br", 40'(e.br), 40'(ctrl.br));
      compare_field("ctrl.mem", 40'(e.mem), 40'(ctrl.mem));
      compare_field("ctrl.wb", 40'(e.wb), 40'(ctrl.wb));
      if (latency_check && (cycle - acc) != 2)
      begin
        $display("Mismatch at %0t: latency expected 2 got %0d", $time, cycle - acc);
        error_count++;
      end
    end
    out_count++;
  endtask

  always @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      error_count = 0;
      out_count   = 0;
      pending     = 0;
      cycle       = 0;
      stalled     = 1'b0;
      exp_q.delete();
      accept_q.delete();
    end
    else
    begin
      cycle++;
      // A stalled bundle must stay put until taken
      if (stalled && !ctrl_valid)
      begin
        $display("Mismatch at %0t: ctrl_valid expected 1 got 0", $time);
        error_count++;
      end
      if (stalled && ctrl !== held_ctrl)
      begin
        $display("Mismatch at %0t: ctrl expected %h got %h", $time, held_ctrl, ctrl);
        error_count++;
      end
      if (inst_valid && inst_ready)
      begin
        exp_q.push_back(expected_ctrl(instruction));
        accept_q.push_back(cycle);
      end
      if (ctrl_valid && ctrl_ready)
        check_output();
      stalled   = ctrl_valid && !ctrl_ready;
      held_ctrl = ctrl;
      pending   = exp_q.size();
    end
  end

endmodule

// File: test/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage
  import decode_pkg::*;
();

  localparam int WAIT_LIMIT = 1000;

  logic         clk;
  logic         arst_n;
  inst_t        instruction;
  logic         inst_valid;
  logic         inst_ready;
  decode_ctrl_t ctrl;
  logic         ctrl_valid;
  logic         ctrl_ready;
  logic         latency_check;

  int     error_count;
  int     out_count;
  int     pending;
  integer seed;
  logic   rand_ready;
  logic   timed_out;
  int     stall_cycles;
  int     tests_run;
  int     tests_failed;
  int     errors_at_start;
  int     outs_at_start;
  inst_t  class_words [15];
  inst_t  zero_words [4];

  decode_stage DUT (
    .clk         (clk),
    .arst_n      (arst_n),
    .instruction (instruction),
    .inst_valid  (inst_valid),
    .inst_ready  (inst_ready),
    .ctrl        (ctrl),
    .ctrl_valid  (ctrl_valid),
    .ctrl_ready  (ctrl_ready)
  );

  decode_checker u_checker (
    .clk           (clk),
    .arst_n        (arst_n),
    .instruction   (instruction),
    .inst_valid    (inst_valid),
    .inst_ready    (inst_ready),
    .ctrl          (ctrl),
    .ctrl_valid    (ctrl_valid),
    .ctrl_ready    (ctrl_ready),
    .latency_check (latency_check),
    .error_count   (error_count),
    .out_count     (out_count),
    .pending       (pending)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Advance one clock and change inputs 2 ns after the edge
  task automatic tick();
    logic [31:0] r;
    @(posedge clk);
    #2;
    if (rand_ready)
    begin
      r = $random(seed);
      ctrl_ready = (r[1:0] != 2'b00);
    end
  endtask

  task automatic send_word(input inst_t w);
    int waited;
    waited      = 0;
    instruction = w;
    inst_valid  = 1'b1;
    while (!inst_ready && !timed_out && waited < WAIT_LIMIT)
    begin
      tick();
      waited++;
    end
    if (!inst_ready && !timed_out)
    begin
      $display("Timeout at %0t: inst_ready stayed low for %0d cycles", $time, waited);
      timed_out = 1'b1;
    end
    stall_cycles += waited;
    if (!timed_out)
      tick();
    inst_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (pending != 0 && !timed_out && waited < WAIT_LIMIT)
    begin
      tick();
      waited++;
    end
    if (pending != 0 && !timed_out)
    begin
      $display("Timeout at %0t: %0d decoded words never left the stage", $time, pending);
      timed_out = 1'b1;
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic got_v,
                           inout logic ok);
    if (exp_v !== got_v)
    begin
      $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp_v, got_v);
      ok = 1'b0;
    end
  endtask

  task automatic start_test();
    errors_at_start = error_count;
    outs_at_start   = out_count;
    stall_cycles    = 0;
  endtask

  task automatic end_test(input string name, input logic ok);
    tests_run++;
    if (ok && !timed_out && error_count == errors_at_start)
      $display("Test %s: ok", name);
    else
    begin
      tests_failed++;
      $display("Test %s: FAILED", name);
    end
  endtask

  initial
  begin
    logic        ok;
    logic [31:0] r;
    int          n;
    seed          = 32'h3bae;
    arst_n        = 1'b0;
    instruction   = '0;
    inst_valid    = 1'b0;
    ctrl_ready    = 1'b1;
    latency_check = 1'b0;
    rand_ready    = 1'b0;
    timed_out     = 1'b0;
    stall_cycles  = 0;
    tests_run     = 0;
    tests_failed  = 0;
    class_words   = '{16'h0000, 16'h1c5a, 16'h1357, 16'h2a95, 16'h3384,
                      16'h4b7f, 16'h5b12, 16'h6345, 16'h7a9c, 16'h8a21,
                      16'h9512, 16'ha3c1, 16'hb35f, 16'hf9ab, 16'hf3ff};
    zero_words    = '{16'hc123, 16'hdfff, 16'he456, 16'hefff};
    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;

    start_test();
    ok = 1'b1;
    check_bit("inst_ready", 1'b0, inst_ready, ok);
    n = 0;
    while (!inst_ready && n < WAIT_LIMIT)
    begin
      tick();
      n++;
    end
    if (!inst_ready)
    begin
      $display("Timeout at %0t: inst_ready never rose after reset", $time);
      timed_out = 1'b1;
    end
    else if (n != 1)
    begin
      $display("Mismatch at %0t: inst_ready rise expected 1 cycle got %0d", $time, n);
      ok = 1'b0;
    end
    check_bit("ctrl_valid", 1'b0, ctrl_valid, ok);
    end_test("reset", ok);

    start_test();
    latency_check = 1'b1;
    foreach (class_words[i])
    begin
      send_word(class_words[i]);
      wait_drain();
    end
    end_test("one word per class", out_count - outs_at_start == 15);

    start_test();
    foreach (zero_words[i])
    begin
      send_word(zero_words[i]);
      wait_drain();
    end
    end_test("reserved and push/pop", out_count - outs_at_start == 4);

    start_test();
    for (int i = 0; i < 200; i++)
    begin
      r = $random(seed);
      send_word(r[15:0]);
    end
    wait_drain();
    if (stall_cycles != 0)
      $display("Error: fetch stalled %0d cycles with no back-pressure", stall_cycles);
    end_test("back-to-back stream", stall_cycles == 0 && out_count - outs_at_start == 200);
    latency_check = 1'b0;

    start_test();
    rand_ready = 1'b1;
    for (int i = 0; i < 300; i++)
    begin
      r = $random(seed);
      send_word(r[15:0]);
    end
    wait_drain();
    rand_ready = 1'b0;
    ctrl_ready = 1'b1;
    end_test("random back-pressure", out_count - outs_at_start == 300);

    start_test();
    ctrl_ready = 1'b0;
    for (int i = 0; i < 3; i++)
    begin
      r = $random(seed);
      send_word(r[15:0]);
    end
    ok = (stall_cycles == 0);
    if (!ok)
      $display("Error: one of the first three words was not accepted at once");
    check_bit("inst_ready", 1'b0, inst_ready, ok);
    repeat (3) tick();
    check_bit("inst_ready", 1'b0, inst_ready, ok);
    check_bit("ctrl_valid", 1'b1, ctrl_valid, ok);
    ctrl_ready = 1'b1;
    wait_drain();
    end_test("held back-pressure", ok && out_count - outs_at_start == 3);

    $display("Summary: %0d tests run, %0d failed, %0d outputs checked, %0d errors",
             tests_run, tests_failed, out_count, error_count);
    if (timed_out || tests_failed != 0 || error_count != 0)
      $display("tests failed");
    else
      $display("all tests passed");
    $finish;
  end

endmodule

// File: verilog/ctrl_out_reg.sv
`timescale 1ns/1ps

module ctrl_out_reg
  import decode_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,

  input  decode_ctrl_t ctrl_in,
  input  logic         in_valid,
  output logic         in_ready,

  output decode_ctrl_t ctrl,
  output logic         ctrl_valid,
  input  logic         ctrl_ready
);

  // Slot takes a new bundle when empty or being emptied
  assign in_ready = !ctrl_valid || ctrl_ready;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      ctrl_valid <= 1'b0;
    else if (in_ready)
      ctrl_valid <= in_valid;
  end

  always_ff @(posedge clk)
  begin
    if (in_ready && in_valid)
      ctrl <= ctrl_in;
  end

  a_stall_stable: assert property (
    @(posedge clk) disable iff (!arst_n)
    (ctrl_valid && !ctrl_ready) |=> (ctrl_valid && $stable(ctrl))
  );

endmodule

// File: verilog/decode_pkg.sv
package decode_pkg;

  localparam int INST_W     = 16;
  localparam int REG_ADDR_W = 4;
  localparam int DATA_W     = 32;
  localparam int ALU_OP_W   = 4;
  localparam int BR_CODE_W  = 3;
  localparam int SRC_SEL_W  = 2;
  localparam int FLAGS_W    = 4;

  typedef logic [INST_W-1:0]     inst_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [ALU_OP_W-1:0]   alu_opcode_t;
  typedef logic [BR_CODE_W-1:0]  branch_code_t;
  typedef logic [SRC_SEL_W-1:0]  src_sel_t;

  typedef struct packed {
    reg_addr_t rd_addr;
    reg_addr_t rn_addr;
    data_t     literal;
  } reg_fetch_ctrl_t;

  typedef struct packed {
    logic               op2_select;
    logic               ext_8_16;
    alu_opcode_t        opcode;
    logic [FLAGS_W-1:0] store_flags;
  } alu_ctrl_t;

  typedef struct packed {
    logic         is_branch;
    logic         is_cond_branch;
    branch_code_t code;
  } branch_ctrl_t;

  typedef struct packed {
    logic     write;
    logic     read;
    src_sel_t data_src;
    src_sel_t addr_src;
  } mem_ctrl_t;

  typedef struct packed {
    logic      write;
    src_sel_t  source;
    reg_addr_t addr;
  } wb_ctrl_t;

  typedef struct packed {
    reg_fetch_ctrl_t rf;
    alu_ctrl_t       alu;
    branch_ctrl_t    br;
    mem_ctrl_t       mem;
    wb_ctrl_t        wb;
  } decode_ctrl_t;

  // Class prefix sits in bits 15:13 and bit 12 splits NOP/EXT and push-pop/branch
  localparam int IDENT_HI = 15, IDENT_LO = 13;
  localparam int IDENT_SUB_BIT = 12;
  localparam logic [2:0] CLS_NOP_EXT   = 3'b000;
  localparam logic [2:0] CLS_BCOND     = 3'b001;
  localparam logic [2:0] CLS_MOV       = 3'b010;
  localparam logic [2:0] CLS_LDSTR     = 3'b011;
  localparam logic [2:0] CLS_ALU       = 3'b100;
  localparam logic [2:0] CLS_SHIFT     = 3'b101;
  localparam logic [2:0] CLS_RES       = 3'b110;
  localparam logic [2:0] CLS_PUPO_BUNC = 3'b111;

  localparam alu_opcode_t ALU_AND = 4'h0;
  localparam alu_opcode_t ALU_OR  = 4'h1;
  localparam alu_opcode_t ALU_XOR = 4'h2;
  localparam alu_opcode_t ALU_NOT = 4'h3;
  localparam alu_opcode_t ALU_NEG = 4'h4;
  localparam alu_opcode_t ALU_MUL = 4'h5;
  localparam alu_opcode_t ALU_DIV = 4'h6;
  localparam alu_opcode_t ALU_REM = 4'h7;
  localparam alu_opcode_t ALU_ADD = 4'h8;
  localparam alu_opcode_t ALU_SUB = 4'h9;
  localparam alu_opcode_t ALU_SEX = 4'ha;
  localparam alu_opcode_t ALU_ZEX = 4'hb;
  localparam alu_opcode_t ALU_LSR = 4'hc;
  localparam alu_opcode_t ALU_LSL = 4'hd;
  localparam alu_opcode_t ALU_ASR = 4'he;
  localparam alu_opcode_t ALU_MOV = 4'hf;

  // Shared by all classes that have them
  localparam int SRC_BIT  = 12;
  localparam int LINK_BIT = 11;

  localparam int EXT_RD_HI = 7, EXT_RD_LO = 4;
  localparam int EXT_ZERO_BIT = 11, EXT_8_16_BIT = 10;
  localparam int BC_RN_HI = 3, BC_RN_LO = 0;
  localparam int BC_LIT_HI = 7, BC_LIT_LO = 0;
  localparam int BC_CODE_HI = 10, BC_CODE_LO = 8;
  localparam int MOV_RD_HI = 11, MOV_RD_LO = 8;
  localparam int MOV_RN_HI = 3, MOV_RN_LO = 0;
  localparam int MOV_LIT_HI = 7, MOV_LIT_LO = 0;
  localparam int LS_STORE_BIT = 12;
  localparam int LS_REG_HI = 11, LS_REG_LO = 8;
  localparam int LS_BASE_HI = 7, LS_BASE_LO = 4;
  localparam int LS_LIT_HI = 3, LS_LIT_LO = 0;
  localparam int ALU_RD_HI = 7, ALU_RD_LO = 4;
  localparam int ALU_RN_HI = 3, ALU_RN_LO = 0;
  localparam int ALU_LIT_HI = 3, ALU_LIT_LO = 0;
  localparam int ALU_OP_HI = 11, ALU_OP_LO = 8;
  localparam int SH_RD_HI = 11, SH_RD_LO = 8;
  localparam int SH_RN_HI = 3, SH_RN_LO = 0;
  localparam int SH_LIT_HI = 4, SH_LIT_LO = 0;
  localparam int SH_OP_HI = 7, SH_OP_LO = 6;
  localparam int BU_RD_HI = 3, BU_RD_LO = 0;
  localparam int BU_LIT_HI = 9, BU_LIT_LO = 0;

  localparam src_sel_t WB_SRC_ALU    = 2'd0;
  localparam src_sel_t WB_SRC_MEM    = 2'd1;
  localparam src_sel_t WB_SRC_BRANCH = 2'd2;

  localparam src_sel_t MEM_DATA_RN  = 2'd0;
  localparam src_sel_t MEM_DATA_RD  = 2'd1;
  localparam src_sel_t MEM_DATA_ALU = 2'd2;
  localparam src_sel_t MEM_DATA_LIT = 2'd3;

  localparam src_sel_t MEM_ADDR_ALU = 2'd0;
  localparam src_sel_t MEM_ADDR_RN  = 2'd1;
  localparam src_sel_t MEM_ADDR_RD  = 2'd2;
  localparam src_sel_t MEM_ADDR_LIT = 2'd3;

  localparam logic OP2_SRC_REG = 1'b0;
  localparam logic OP2_SRC_LIT = 1'b1;

  localparam reg_addr_t LINK_REG = 4'd14;

endpackage

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
  import decode_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,

  input  inst_t        instruction,
  input  logic         inst_valid,
  output logic         inst_ready,

  output decode_ctrl_t ctrl,
  output logic         ctrl_valid,
  input  logic         ctrl_ready
);

  inst_t        buf_inst;
  logic         buf_valid;
  logic         buf_ready;
  decode_ctrl_t dec_ctrl;

  inst_skid_buffer u_skid (
    .clk         (clk),
    .arst_n      (arst_n),
    .instruction (instruction),
    .inst_valid  (inst_valid),
    .inst_ready  (inst_ready),
    .buf_inst    (buf_inst),
    .buf_valid   (buf_valid),
    .buf_ready   (buf_ready)
  );

  inst_decoder u_dec (
    .instruction (buf_inst),
    .ctrl        (dec_ctrl)
  );

  ctrl_out_reg u_out (
    .clk        (clk),
    .arst_n     (arst_n),
    .ctrl_in    (dec_ctrl),
    .in_valid   (buf_valid),
    .in_ready   (buf_ready),
    .ctrl       (ctrl),
    .ctrl_valid (ctrl_valid),
    .ctrl_ready (ctrl_ready)
  );

endmodule

// File: verilog/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
  import decode_pkg::*;
(
  input  inst_t        instruction,
  output decode_ctrl_t ctrl
);

  logic [2:0] ident;
  logic       sub_bit;
  logic       op2_by_src;

  assign ident      = instruction[IDENT_HI:IDENT_LO];
  assign sub_bit    = instruction[IDENT_SUB_BIT];
  assign op2_by_src = instruction[SRC_BIT] ? OP2_SRC_REG : OP2_SRC_LIT;

  always_comb
  begin
    ctrl = '0;
    case (ident)
      CLS_NOP_EXT:
      begin
        // NOP keeps the all-zero bundle
        if (sub_bit)
        begin
          ctrl.rf.rd_addr    = instruction[EXT_RD_HI:EXT_RD_LO];
          ctrl.alu.op2_select = OP2_SRC_REG;
          ctrl.alu.ext_8_16  = instruction[EXT_8_16_BIT];
          ctrl.alu.opcode    = instruction[EXT_ZERO_BIT] ? ALU_ZEX : ALU_SEX;
          ctrl.wb.write      = 1'b1;
          ctrl.wb.source     = WB_SRC_ALU;
          ctrl.wb.addr       = instruction[EXT_RD_HI:EXT_RD_LO];
        end
      end

      CLS_BCOND:
      begin
        ctrl.rf.rn_addr       = instruction[BC_RN_HI:BC_RN_LO];
        ctrl.rf.literal       = {{(DATA_W-8){instruction[BC_LIT_HI]}},
                                 instruction[BC_LIT_HI:BC_LIT_LO]};
        ctrl.alu.op2_select   = op2_by_src;
        ctrl.alu.opcode       = ALU_MOV;
        ctrl.br.is_branch     = 1'b1;
        ctrl.br.is_cond_branch = 1'b1;
        ctrl.br.code          = instruction[BC_CODE_HI:BC_CODE_LO];
        ctrl.wb.write         = instruction[LINK_BIT];
        ctrl.wb.source        = WB_SRC_BRANCH;
        ctrl.wb.addr          = LINK_REG;
      end

      CLS_MOV:
      begin
        ctrl.rf.rn_addr     = instruction[MOV_RN_HI:MOV_RN_LO];
        ctrl.rf.literal     = data_t'(instruction[MOV_LIT_HI:MOV_LIT_LO]);
        ctrl.alu.op2_select = op2_by_src;
        ctrl.alu.opcode     = ALU_MOV;
        ctrl.wb.write       = 1'b1;
        ctrl.wb.source      = WB_SRC_ALU;
        ctrl.wb.addr        = instruction[MOV_RD_HI:MOV_RD_LO];
      end

      CLS_LDSTR:
      begin
        // Address is base plus offset through the ALU
        ctrl.rf.rd_addr     = instruction[LS_BASE_HI:LS_BASE_LO];
        ctrl.rf.rn_addr     = instruction[LS_REG_HI:LS_REG_LO];
        ctrl.rf.literal     = data_t'(instruction[LS_LIT_HI:LS_LIT_LO]);
        ctrl.alu.op2_select = OP2_SRC_LIT;
        ctrl.alu.opcode     = ALU_ADD;
        ctrl.mem.write      = instruction[LS_STORE_BIT];
        ctrl.mem.read       = !instruction[LS_STORE_BIT];
        ctrl.mem.data_src   = MEM_DATA_RN;
        ctrl.mem.addr_src   = MEM_ADDR_ALU;
        ctrl.wb.write       = !instruction[LS_STORE_BIT];
        ctrl.wb.source      = WB_SRC_MEM;
        ctrl.wb.addr        = instruction[LS_REG_HI:LS_REG_LO];
      end

      CLS_ALU:
      begin
        ctrl.rf.rd_addr      = instruction[ALU_RD_HI:ALU_RD_LO];
        ctrl.rf.rn_addr      = instruction[ALU_RN_HI:ALU_RN_LO];
        ctrl.rf.literal      = data_t'(instruction[ALU_LIT_HI:ALU_LIT_LO]);
        ctrl.alu.op2_select  = op2_by_src;
        ctrl.alu.opcode      = instruction[ALU_OP_HI:ALU_OP_LO];
        ctrl.alu.store_flags = '1;
        ctrl.wb.write        = 1'b1;
        ctrl.wb.source       = WB_SRC_ALU;
        ctrl.wb.addr         = instruction[ALU_RD_HI:ALU_RD_LO];
      end

      CLS_SHIFT:
      begin
        ctrl.rf.rd_addr      = instruction[SH_RD_HI:SH_RD_LO];
        ctrl.rf.rn_addr      = instruction[SH_RN_HI:SH_RN_LO];
        ctrl.rf.literal      = data_t'(instruction[SH_LIT_HI:SH_LIT_LO]);
        ctrl.alu.op2_select  = op2_by_src;
        // LSR, LSL, ASR follow each other in the opcode map
        ctrl.alu.opcode      = ALU_LSR + alu_opcode_t'(instruction[SH_OP_HI:SH_OP_LO]);
        ctrl.alu.store_flags = '1;
        ctrl.wb.write        = 1'b1;
        ctrl.wb.source       = WB_SRC_ALU;
        ctrl.wb.addr         = instruction[SH_RD_HI:SH_RD_LO];
      end

      CLS_RES:
        ctrl = '0;

      CLS_PUPO_BUNC:
      begin
        // Push/pop is not supported and stays all zero
        if (sub_bit)
        begin
          ctrl.rf.rd_addr   = instruction[BU_RD_HI:BU_RD_LO];
          ctrl.rf.literal   = data_t'(instruction[BU_LIT_HI:BU_LIT_LO]);
          ctrl.br.is_branch = 1'b1;
          ctrl.wb.write     = instruction[LINK_BIT];
          ctrl.wb.source    = WB_SRC_BRANCH;
          ctrl.wb.addr      = LINK_REG;
        end
      end

      default:
        ctrl = '0;
    endcase
  end

endmodule

// File: verilog/inst_skid_buffer.sv
`timescale 1ns/1ps

module inst_skid_buffer
  import decode_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,

  input  inst_t instruction,
  input  logic  inst_valid,
  output logic  inst_ready,

  output inst_t buf_inst,
  output logic  buf_valid,
  input  logic  buf_ready
);

  inst_t skid_inst;
  logic  skid_valid;
  logic  in_fire;
  logic  main_free;

  assign in_fire   = inst_valid && inst_ready;
  // Main entry can take a word when empty or draining this cycle
  assign main_free = !buf_valid || buf_ready;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      buf_valid  <= 1'b0;
      skid_valid <= 1'b0;
      inst_ready <= 1'b0;
    end
    else if (main_free)
    begin
      // Skid entry drains first; fetch is stalled while it holds a word
      buf_valid  <= skid_valid || in_fire;
      skid_valid <= 1'b0;
      inst_ready <= 1'b1;
    end
    else if (in_fire)
    begin
      skid_valid <= 1'b1;
      inst_ready <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (main_free)
      buf_inst <= skid_valid ? skid_inst : instruction;
    if (!main_free && in_fire)
      skid_inst <= instruction;
  end

  // Registered ready must already be low once both entries hold a word
  a_no_accept_when_full: assert property (
    @(posedge clk) disable iff (!arst_n)
    (buf_valid && skid_valid) |-> !(inst_valid && inst_ready)
  );

endmodule
